// ==== axi_pkg.sv ====
/*
 * AXI4 package for the ATOP filter subsystem.
 * Holds the fixed bus widths, the channel structs, the master and
 * slave bundles, and the ATOP class and response code enums.
 */
`default_nettype none

package axi_pkg;

  // Fixed bus widths, shared by every block of the subsystem.
  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [7:0]           len_t;

  // ATOP class, taken from bits [5:4] of the atop field.
  typedef enum logic [1:0] {
    ATOP_NONE          = 2'b00,
    ATOP_ATOMICSTORE   = 2'b01,
    ATOP_ATOMICLOAD    = 2'b10,
    ATOP_ATOMICSWAPCMP = 2'b11
  } atop_kind_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  typedef struct packed {
    id_t        id;
    addr_t      addr;
    len_t       len;
    logic [2:0] size;
    logic [1:0] burst;
    logic [5:0] atop;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_e resp;
  } b_chan_t;

  typedef struct packed {
    id_t        id;
    addr_t      addr;
    len_t       len;
    logic [2:0] size;
    logic [1:0] burst;
  } ar_chan_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_e resp;
    logic  last;
  } r_chan_t;

  // Everything a master drives towards a slave.
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Everything a slave drives back towards its master.
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } axi_resp_t;

endpackage

`default_nettype wire

// ==== stream_register.sv ====
/*
 * One-entry valid/ready register.
 * Holds a single item of any payload type and accepts a new one
 * on the same cycle that the held item is taken.
 */
`default_nettype none

module stream_register #(
  parameter type T = logic
) (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic valid_i,
  output logic      ready_o,
  input  wire T     data_i,
  output logic      valid_o,
  input  wire logic ready_i,
  output T          data_o
);

  logic valid_q;
  T     data_q;

  // Free when empty, or when the held item leaves on this cycle.
  assign ready_o = !valid_q || ready_i;
  assign valid_o = valid_q;
  assign data_o  = data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // The payload only loads on an accepted push.
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== axi_atop_filter.sv ====
/*
 * AXI ATOP filter.
 * Forwards normal traffic from the slave port to the master port and
 * absorbs every write with a non-zero atop field. Absorbed bursts get an
 * SLVERR write response and, unless they are atomic stores, one SLVERR
 * read beat per write beat. The atop field on the master port is zero.
 */
`default_nettype none

module axi_atop_filter import axi_pkg::*; #(
  parameter int unsigned MaxWriteTxns = 2
) (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  input  wire axi_req_t  slv_req_i,
  output axi_resp_t      slv_resp_o,
  output axi_req_t       mst_req_o,
  input  wire axi_resp_t mst_resp_i
);

  typedef logic [$clog2(MaxWriteTxns+1)-1:0] cnt_t;

  typedef enum logic [2:0] {
    W_FEEDTHROUGH,
    BLOCK_AW,
    ABSORB_W,
    INJECT_B,
    WAIT_R
  } w_state_e;

  typedef enum logic {
    R_FEEDTHROUGH,
    INJECT_R
  } r_state_e;

  // Command for the read side, carrying the length of the absorbed burst.
  typedef struct packed {
    len_t len;
  } r_resp_cmd_t;

  w_state_e    w_state_d, w_state_q;
  r_state_e    r_state_d, r_state_q;
  cnt_t        w_cnt_d, w_cnt_q;
  id_t         id_d, id_q;
  len_t        r_beats_d, r_beats_q;
  r_resp_cmd_t cmd_push, cmd_pop;
  logic        cmd_push_valid;
  logic        cmd_pop_valid, cmd_pop_ready;

  // Handshake decisions of the write side.
  logic mst_aw_valid, slv_aw_ready;
  logic mst_w_valid, slv_w_ready;
  logic inject_b;

  // Read side injection control.
  logic inject_r;
  logic inject_last;

  logic is_atop;
  logic needs_r;

  assign is_atop  = slv_req_i.aw_valid && (slv_req_i.aw.atop != '0);
  // Every class except atomic store also returns read data.
  assign needs_r  = atop_kind_e'(slv_req_i.aw.atop[5:4]) != ATOP_ATOMICSTORE;
  assign cmd_push = '{len: slv_req_i.aw.len};
  assign inject_b = (w_state_q == INJECT_B);

  // Write-side FSM for the AW, W and B channels.
  always_comb begin
    mst_aw_valid   = 1'b0;
    slv_aw_ready   = 1'b0;
    mst_w_valid    = 1'b0;
    slv_w_ready    = 1'b0;
    id_d           = id_q;
    cmd_push_valid = 1'b0;
    w_state_d      = w_state_q;

    unique case (w_state_q)
      W_FEEDTHROUGH: begin
        // AW passes while the downstream burst limit is not reached.
        if (w_cnt_q < cnt_t'(MaxWriteTxns)) begin
          mst_aw_valid = slv_req_i.aw_valid;
          slv_aw_ready = mst_resp_i.aw_ready;
        end
        // W beats only pass once their AW has gone downstream.
        if (w_cnt_q != '0) begin
          mst_w_valid = slv_req_i.w_valid;
          slv_w_ready = mst_resp_i.w_ready;
        end
        if (is_atop) begin
          // Take the ATOP here and keep it away from the master port.
          mst_aw_valid   = 1'b0;
          slv_aw_ready   = 1'b1;
          id_d           = slv_req_i.aw.id;
          // The register is empty here, so the push cannot be refused.
          cmd_push_valid = needs_r;
          if (w_cnt_q != '0) begin
            // Earlier bursts still own the W channel.
            w_state_d = BLOCK_AW;
          end else begin
            mst_w_valid = 1'b0;
            slv_w_ready = 1'b1;
            if (slv_req_i.w_valid && slv_req_i.w.last) begin
              w_state_d = INJECT_B;
            end else begin
              w_state_d = ABSORB_W;
            end
          end
        end
      end

      BLOCK_AW: begin
        if (w_cnt_q != '0) begin
          // Drain the W beats of the bursts already sent downstream.
          mst_w_valid = slv_req_i.w_valid;
          slv_w_ready = mst_resp_i.w_ready;
        end else begin
          slv_w_ready = 1'b1;
          if (slv_req_i.w_valid && slv_req_i.w.last) begin
            w_state_d = INJECT_B;
          end else begin
            w_state_d = ABSORB_W;
          end
        end
      end

      ABSORB_W: begin
        slv_w_ready = 1'b1;
        if (slv_req_i.w_valid && slv_req_i.w.last) begin
          w_state_d = INJECT_B;
        end
      end

      INJECT_B: begin
        // Leave only after the read side has finished its beats too.
        if (slv_req_i.b_ready) begin
          if (cmd_pop_valid && !cmd_pop_ready) begin
            w_state_d = WAIT_R;
          end else begin
            w_state_d = W_FEEDTHROUGH;
          end
        end
      end

      WAIT_R: begin
        if (!cmd_pop_valid) begin
          w_state_d = W_FEEDTHROUGH;
        end
      end

      default: w_state_d = W_FEEDTHROUGH;
    endcase
  end

  // Injection starts at once if no downstream beat is on offer, so a
  // presented downstream beat is never pulled back.
  assign inject_r = (r_state_q == INJECT_R) ||
                    (cmd_pop_valid && !mst_resp_i.r_valid);
  assign inject_last = (r_beats_q == cmd_pop.len);

  // Read-side FSM; r_beats_q counts the injected beats already taken.
  always_comb begin
    r_beats_d     = r_beats_q;
    r_state_d     = r_state_q;
    cmd_pop_ready = 1'b0;
    if (inject_r) begin
      r_state_d = INJECT_R;
      if (slv_req_i.r_ready) begin
        if (inject_last) begin
          cmd_pop_ready = 1'b1;
          r_beats_d     = '0;
          r_state_d     = R_FEEDTHROUGH;
        end else begin
          r_beats_d = r_beats_q + 8'd1;
        end
      end
    end
  end

  // Count bursts whose AW went downstream and whose last W beat has not.
  always_comb begin
    w_cnt_d = w_cnt_q;
    if (mst_aw_valid && mst_resp_i.aw_ready) begin
      w_cnt_d = w_cnt_d + cnt_t'(1);
    end
    if (mst_w_valid && mst_resp_i.w_ready && slv_req_i.w.last) begin
      w_cnt_d = w_cnt_d - cnt_t'(1);
    end
  end

  // Build both port bundles from the pass-through defaults.
  always_comb begin
    mst_req_o          = slv_req_i;
    mst_req_o.aw.atop  = '0;
    mst_req_o.aw_valid = mst_aw_valid;
    mst_req_o.w_valid  = mst_w_valid;
    mst_req_o.b_ready  = slv_req_i.b_ready && !inject_b;
    mst_req_o.r_ready  = slv_req_i.r_ready && !inject_r;

    slv_resp_o          = mst_resp_i;
    slv_resp_o.aw_ready = slv_aw_ready;
    slv_resp_o.w_ready  = slv_w_ready;
    if (inject_b) begin
      slv_resp_o.b       = '{id: id_q, resp: RESP_SLVERR};
      slv_resp_o.b_valid = 1'b1;
    end
    if (inject_r) begin
      slv_resp_o.r = '{id: id_q, data: '0, resp: RESP_SLVERR, last: inject_last};
      slv_resp_o.r_valid = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_state_q <= W_FEEDTHROUGH;
      r_state_q <= R_FEEDTHROUGH;
      w_cnt_q   <= '0;
      id_q      <= '0;
      r_beats_q <= '0;
    end else begin
      w_state_q <= w_state_d;
      r_state_q <= r_state_d;
      w_cnt_q   <= w_cnt_d;
      id_q      <= id_d;
      r_beats_q <= r_beats_d;
    end
  end

  stream_register #(
    .T(r_resp_cmd_t)
  ) i_r_resp_cmd (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (cmd_push_valid),
    .ready_o (),
    .data_i  (cmd_push),
    .valid_o (cmd_pop_valid),
    .ready_i (cmd_pop_ready),
    .data_o  (cmd_pop)
  );

endmodule

`default_nettype wire

// ==== axi_sram_slave.sv ====
/*
 * Word array behind an AXI4 slave port.
 * Serves one INCR write burst and one INCR read burst at a time,
 * with independent engines. Beats past the end of the array are
 * dropped on write, read as zero, and answered with DECERR.
 */
`default_nettype none

module axi_sram_slave import axi_pkg::*; #(
  parameter int unsigned MemWords = 64
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire axi_req_t req_i,
  output axi_resp_t     resp_o
);

  localparam int unsigned IdxWidth = $clog2(MemWords);

  // Word index, the byte address without its lane bits.
  typedef logic [AddrWidth-3:0] word_t;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  typedef enum logic {
    RD_IDLE,
    RD_DATA
  } rd_state_e;

  data_t     mem_q [MemWords];
  wr_state_e wr_state_q;
  rd_state_e rd_state_q;
  id_t       wr_id_q, rd_id_q;
  word_t     wr_word_q, rd_word_q;
  len_t      wr_len_q, rd_len_q;
  logic      wr_err_q;
  logic      wr_in_range, rd_in_range;

  assign wr_in_range = wr_word_q < MemWords;
  assign rd_in_range = rd_word_q < MemWords;

  always_comb begin
    resp_o          = '0;
    resp_o.aw_ready = (wr_state_q == WR_IDLE);
    resp_o.w_ready  = (wr_state_q == WR_DATA);
    resp_o.b_valid  = (wr_state_q == WR_RESP);
    resp_o.b.id     = wr_id_q;
    resp_o.b.resp   = wr_err_q ? RESP_DECERR : RESP_OKAY;
    resp_o.ar_ready = (rd_state_q == RD_IDLE);
    resp_o.r_valid  = (rd_state_q == RD_DATA);
    resp_o.r.id     = rd_id_q;
    resp_o.r.data   = rd_in_range ? mem_q[rd_word_q[IdxWidth-1:0]] : '0;
    resp_o.r.resp   = rd_in_range ? RESP_OKAY : RESP_DECERR;
    resp_o.r.last   = (rd_len_q == '0);
  end

  // Write engine, which also owns the array.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_state_q <= WR_IDLE;
      wr_id_q    <= '0;
      wr_word_q  <= '0;
      wr_len_q   <= '0;
      wr_err_q   <= 1'b0;
      for (int i = 0; i < MemWords; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      unique case (wr_state_q)
        WR_IDLE: begin
          if (req_i.aw_valid) begin
            wr_id_q    <= req_i.aw.id;
            wr_word_q  <= req_i.aw.addr[AddrWidth-1:2];
            wr_len_q   <= req_i.aw.len;
            wr_err_q   <= 1'b0;
            wr_state_q <= WR_DATA;
          end
        end
        WR_DATA: begin
          if (req_i.w_valid) begin
            if (wr_in_range) begin
              for (int b = 0; b < StrbWidth; b++) begin
                if (req_i.w.strb[b]) begin
                  mem_q[wr_word_q[IdxWidth-1:0]][8*b +: 8] <= req_i.w.data[8*b +: 8];
                end
              end
            end else begin
              wr_err_q <= 1'b1;
            end
            wr_word_q <= wr_word_q + word_t'(1);
            wr_len_q  <= wr_len_q - 8'd1;
            // The burst length, not WLAST, closes the burst.
            if (wr_len_q == '0) begin
              wr_state_q <= WR_RESP;
            end
          end
        end
        WR_RESP: begin
          if (req_i.b_ready) begin
            wr_state_q <= WR_IDLE;
          end
        end
        default: wr_state_q <= WR_IDLE;
      endcase
    end
  end

  // Read engine. Data comes straight from the array.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_state_q <= RD_IDLE;
      rd_id_q    <= '0;
      rd_word_q  <= '0;
      rd_len_q   <= '0;
    end else begin
      unique case (rd_state_q)
        RD_IDLE: begin
          if (req_i.ar_valid) begin
            rd_id_q    <= req_i.ar.id;
            rd_word_q  <= req_i.ar.addr[AddrWidth-1:2];
            rd_len_q   <= req_i.ar.len;
            rd_state_q <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (req_i.r_ready) begin
            if (rd_len_q == '0) begin
              rd_state_q <= RD_IDLE;
            end else begin
              rd_word_q <= rd_word_q + word_t'(1);
              rd_len_q  <= rd_len_q - 8'd1;
            end
          end
        end
        default: rd_state_q <= RD_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== atop_filter_top.sv ====
/*
 * ATOP filter subsystem top level.
 * Places the ATOP filter in front of the on-chip memory slave
 * and hands both their parameters.
 */
`default_nettype none

module atop_filter_top import axi_pkg::*; #(
  parameter int unsigned MaxWriteTxns = 2,
  parameter int unsigned MemWords     = 64
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire axi_req_t slv_req_i,
  output axi_resp_t     slv_resp_o
);

  // Filtered bus between the filter and the memory.
  axi_req_t  mem_req;
  axi_resp_t mem_resp;

  axi_atop_filter #(
    .MaxWriteTxns(MaxWriteTxns)
  ) i_axi_atop_filter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .slv_req_i  (slv_req_i),
    .slv_resp_o (slv_resp_o),
    .mst_req_o  (mem_req),
    .mst_resp_i (mem_resp)
  );

  axi_sram_slave #(
    .MemWords(MemWords)
  ) i_axi_sram_slave (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (mem_req),
    .resp_o (mem_resp)
  );

endmodule

`default_nettype wire

// ==== tb_atop_filter.sv ====
/*
 * Testbench for the ATOP filter subsystem.
 * Acts as AXI master on the top level and replays the transactions of
 * the golden file. Every B and R response is checked against the file,
 * under random back-pressure on both response channels.
 */
`default_nettype none

module tb_atop_filter import axi_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned MaxWriteTxns  = 2;
  localparam int unsigned MemWords      = 64;
  localparam int unsigned MaxLines      = 64;
  localparam int unsigned CyclesPerLine = 64;
  localparam int unsigned GoldenWidth   = 92;

  // Operation codes of the golden file.
  localparam logic [3:0] OpWrite = 4'h0;
  localparam logic [3:0] OpRead  = 4'h1;
  localparam logic [3:0] OpAtop  = 4'h2;
  localparam logic [3:0] OpEnd   = 4'hF;

  logic      clk_i;
  logic      rst_ni;
  axi_req_t  slv_req;
  axi_resp_t slv_resp;

  logic [GoldenWidth-1:0] golden_mem [MaxLines];

  integer      seed = 32'hb2e2_5c79;
  int unsigned num_lines, cur_line, cycles;
  int unsigned max_cycles = 0;
  int unsigned value_errors, other_errors;
  int unsigned b_seen, r_seen, b_expected, r_expected;

  atop_filter_top #(
    .MaxWriteTxns(MaxWriteTxns),
    .MemWords    (MemWords)
  ) i_atop_filter_top (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .slv_req_i  (slv_req),
    .slv_resp_o (slv_resp)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Inputs change 2 ns after the rising edge; outputs are read at the falling edge.
  task automatic advance_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h (golden line %0d)",
               name, actual, expected, cur_line);
      value_errors++;
    end
  endtask

  task automatic send_aw(input id_t id, input addr_t addr, input len_t len,
                         input logic [5:0] atop);
    logic accepted;
    slv_req.aw       = '{id: id, addr: addr, len: len, size: 3'd2, burst: 2'b01, atop: atop};
    slv_req.aw_valid = 1'b1;
    accepted         = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = slv_resp.aw_ready;
      advance_cycle();
    end
    slv_req.aw_valid = 1'b0;
  endtask

  // Beat i of a burst carries base + i, with all byte lanes enabled.
  task automatic send_w(input len_t len, input data_t base);
    logic accepted;
    for (int i = 0; i <= int'(len); i++) begin
      slv_req.w       = '{data: base + data_t'(i), strb: '1, last: (i == int'(len))};
      slv_req.w_valid = 1'b1;
      accepted        = 1'b0;
      while (!accepted) begin
        @(negedge clk_i);
        accepted = slv_resp.w_ready;
        advance_cycle();
      end
    end
    slv_req.w_valid = 1'b0;
  endtask

  task automatic send_ar(input id_t id, input addr_t addr, input len_t len);
    logic accepted;
    slv_req.ar       = '{id: id, addr: addr, len: len, size: 3'd2, burst: 2'b01};
    slv_req.ar_valid = 1'b1;
    accepted         = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = slv_resp.ar_ready;
      advance_cycle();
    end
    slv_req.ar_valid = 1'b0;
  endtask

  task automatic expect_b(input id_t id, input resp_e resp);
    do @(negedge clk_i); while (!(slv_resp.b_valid && slv_req.b_ready));
    check_value("b.id", 32'(slv_resp.b.id), 32'(id));
    check_value("b.resp", 32'(slv_resp.b.resp), 32'(resp));
    advance_cycle();
  endtask

  // An OKAY beat returns base + i, an error beat from memory returns zero.
  task automatic expect_r(input id_t id, input int unsigned beats, input resp_e resp,
                          input data_t base, input logic check_data);
    data_t exp_data;
    for (int unsigned i = 0; i < beats; i++) begin
      do @(negedge clk_i); while (!(slv_resp.r_valid && slv_req.r_ready));
      exp_data = (resp == RESP_OKAY) ? base + data_t'(i) : '0;
      check_value("r.id", 32'(slv_resp.r.id), 32'(id));
      check_value("r.resp", 32'(slv_resp.r.resp), 32'(resp));
      check_value("r.last", 32'(slv_resp.r.last), 32'(i == beats - 1));
      if (check_data) begin
        check_value("r.data", slv_resp.r.data, exp_data);
      end
      advance_cycle();
    end
  endtask

  // Counts every response handshake, so lost or extra responses show at the end.
  initial begin
    forever begin
      @(negedge clk_i);
      if (rst_ni === 1'b1 && slv_resp.b_valid && slv_req.b_ready) begin
        b_seen++;
      end
      if (rst_ni === 1'b1 && slv_resp.r_valid && slv_req.r_ready) begin
        r_seen++;
      end
    end
  end

  // Random back-pressure, high on about three cycles out of four.
  initial begin
    wait (rst_ni === 1'b1);
    forever begin
      advance_cycle();
      slv_req.b_ready = (($random(seed) & 3) != 0);
      slv_req.r_ready = (($random(seed) & 3) != 0);
    end
  end

  initial begin
    cycles = 0;
    wait (max_cycles != 0);
    while (cycles < max_cycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", max_cycles);
    $display("Verification failed");
    $finish;
  end

  initial begin
    logic [GoldenWidth-1:0] entry;
    logic [3:0]             op;
    id_t                    id;
    addr_t                  addr;
    len_t                   len;
    data_t                  base;
    resp_e                  resp;
    int unsigned            beats;
    logic                   chain;
    id_t                    nx_id;
    addr_t                  nx_addr;
    len_t                   nx_len;
    data_t                  nx_base;
    resp_e                  nx_resp;

    slv_req      = '0;
    rst_ni       = 1'b0;
    value_errors = 0;
    other_errors = 0;
    b_seen       = 0;
    r_seen       = 0;
    b_expected   = 0;
    r_expected   = 0;

    $readmemh("atop_filter_golden.txt", golden_mem);
    num_lines = 0;
    while (num_lines < MaxLines && golden_mem[num_lines][91:88] != OpEnd) begin
      num_lines++;
    end
    if (num_lines == 0 || num_lines == MaxLines) begin
      $display("Golden file is empty or has no end marker");
      other_errors++;
      num_lines = 0;
    end
    max_cycles = num_lines * CyclesPerLine;

    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    advance_cycle();

    for (int unsigned n = 0; n < num_lines; n++) begin
      entry    = golden_mem[n];
      cur_line = n + 1;
      op       = entry[91:88];
      id       = entry[87:84];
      addr     = entry[83:68];
      len      = entry[67:60];
      base     = entry[51:20];
      resp     = resp_e'(entry[17:16]);
      beats    = 32'(entry[15:0]);
      case (op)
        OpWrite: begin
          b_expected++;
          fork
            send_aw(id, addr, len, 6'd0);
            send_w(len, base);
            expect_b(id, resp);
          join
        end
        OpRead: begin
          r_expected += beats;
          fork
            send_ar(id, addr, len);
            expect_r(id, beats, resp, base, 1'b1);
          join
        end
        OpAtop: begin
          // A write on the next line is queued right behind the ATOP, so its
          // AW and W reach the filter while the ATOP is still in progress.
          chain   = (golden_mem[n+1][91:88] == OpWrite);
          nx_id   = golden_mem[n+1][87:84];
          nx_addr = golden_mem[n+1][83:68];
          nx_len  = golden_mem[n+1][67:60];
          nx_base = golden_mem[n+1][51:20];
          nx_resp = resp_e'(golden_mem[n+1][17:16]);
          b_expected += chain ? 2 : 1;
          r_expected += beats;
          // The filter absorbs the burst, so the data it carries is never seen again.
          fork
            begin
              send_aw(id, addr, len, entry[57:52]);
              if (chain) begin
                send_aw(nx_id, nx_addr, nx_len, 6'd0);
              end
            end
            begin
              send_w(len, base);
              if (chain) begin
                send_w(nx_len, nx_base);
              end
            end
            begin
              expect_b(id, resp);
              if (chain) begin
                expect_b(nx_id, nx_resp);
              end
            end
            expect_r(id, beats, resp, '0, 1'b0);
          join
          if (chain) begin
            n++;
          end
        end
        default: begin
          $display("Golden line %0d has an unknown operation code %0h", cur_line, op);
          other_errors++;
        end
      endcase
    end

    // Give a stray response time to show up before the totals are compared.
    repeat (16) advance_cycle();
    if (b_seen != b_expected) begin
      $display("Write responses lost or duplicated: saw %0d, expected %0d",
               b_seen, b_expected);
      other_errors++;
    end
    if (r_seen != r_expected) begin
      $display("Read beats lost or duplicated: saw %0d, expected %0d", r_seen, r_expected);
      other_errors++;
    end

    $display("Checks done: %0d value mismatches, %0d other errors",
             value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== atop_filter_golden.txt ====
// op(0 write,1 read,2 atop,F end)_id_addr_len_atop_seed_resp(0 OKAY,2 SLVERR,3 DECERR)_rbeats
// Write data and expected OKAY read data are seed plus beat index.
0_1_0010_03_00_00001000_0_0000
1_2_0010_03_00_00001000_0_0004
2_3_0010_01_10_DEAD0000_2_0000
1_4_0010_03_00_00001000_0_0004
2_5_0014_02_20_BEEF0000_2_0003
2_6_0018_00_31_CAFE0000_2_0001
0_7_0020_01_00_00002000_0_0000
1_8_0010_03_00_00001000_0_0004
1_9_0020_01_00_00002000_0_0002
0_A_00F8_03_00_00003000_3_0000
1_B_0100_01_00_00000000_3_0002
2_C_0000_03_2A_12340000_2_0004
0_D_0000_00_00_00004000_0_0000
1_E_0000_00_00_00004000_0_0001
1_F_00F8_01_00_00003000_0_0002
F_0_0000_00_00_00000000_0_0000

// ==== vlog.f ====
axi_pkg.sv
stream_register.sv
axi_atop_filter.sv
axi_sram_slave.sv
atop_filter_top.sv
tb_atop_filter.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_atop_filter
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
